// File: sim.f
src/bufreg_pkg.sv
src/core_stack.sv
src/sense_arbiter.sv
src/buffer_register.sv
src/axil_bufreg_port.sv
src/bufreg_top.sv
test/bufreg_asserts.sv
test/tb_bufreg.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_bufreg \
    -Mdir obj_dir -o tb_bufreg
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_bufreg > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// File: test/tb_bufreg.sv
`timescale 1ns/1ps

module tb_bufreg import bufreg_pkg::*; ();

    localparam int OP_WR   = 0;
    localparam int OP_HOLD = 1;
    localparam int OP_RD   = 2;
    localparam int OP_POLL = 3;

    logic        v1;
    logic        arst_n;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // stimulus table, one entry per AXI operation
    int          t_op[$];
    logic [11:0] t_addr[$];
    logic [31:0] t_data[$];
    logic [31:0] t_exp[$];
    logic [1:0]  t_resp[$];

    // reference model of the stacks and the buffer register
    word_t stack_mem [4][16];
    word_t br_model;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;

    bufreg_top DUT (.*);

    initial begin
        v1 = 1'b0;
        forever #5 v1 = ~v1;
    end

    always @(posedge v1) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the test sequence did not complete", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR time=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] expected_read(input logic [11:0] addr);
        case (addr)
            REG_BR:  return {20'h0, br_model};
            REG_BRN: return {20'h0, ~br_model};
            default: return 32'h0;
        endcase
    endfunction

    task automatic apply_to_model(input logic [11:0] addr, input word_t d);
        if (addr == REG_BR) begin
            br_model = '0;
        end else if (addr == REG_TRY) begin
            br_model = br_model | (d & 12'hFC0);
        end else if (addr == REG_TRZ) begin
            br_model = br_model | (d & 12'h03F);
        end else if (addr == REG_GATHER) begin
            for (int s = 0; s < 4; s++) begin
                if (d[4 + s]) begin
                    br_model = br_model | stack_mem[s][d[3:0]];
                end
            end
        end else if (addr[11:8] == STACK_BASE[11:8]) begin
            stack_mem[addr[7:6]][addr[5:2]] = d;
        end
    endtask

    task automatic add_step(input int op, input logic [11:0] addr, input logic [31:0] data,
                            input logic [1:0] resp);
        logic [31:0] exp;
        exp = '0;
        if (op == OP_RD) begin
            exp = expected_read(addr);
        end else if ((op == OP_WR || op == OP_HOLD) && resp == RESP_OKAY) begin
            apply_to_model(addr, data[11:0]);
        end
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_exp.push_back(exp);
        t_resp.push_back(resp);
    endtask

    // gather, wait for idle, then read both rails back
    task automatic add_gather(input stack_mask_t mask, input waddr_t wa);
        add_step(OP_WR, REG_GATHER, {24'h0, mask, wa}, RESP_OKAY);
        add_step(OP_POLL, REG_STATUS, 32'h0, RESP_OKAY);
        add_step(OP_RD, REG_BR, 32'h0, RESP_OKAY);
        add_step(OP_RD, REG_BRN, 32'h0, RESP_OKAY);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [1:0]  s2;
        waddr_t      wa;
        br_model = '0;
        add_step(OP_RD, REG_BR, 32'h0, RESP_OKAY);
        add_step(OP_RD, REG_BRN, 32'h0, RESP_OKAY);
        add_step(OP_RD, REG_STATUS, 32'h0, RESP_OKAY);
        add_step(OP_WR, REG_TRZ, 32'h0000_0A95, RESP_OKAY);
        add_step(OP_RD, REG_BR, 32'h0, RESP_OKAY);
        add_step(OP_RD, REG_BRN, 32'h0, RESP_OKAY);
        add_step(OP_WR, REG_TRY, 32'h0000_0FFF, RESP_OKAY);
        add_step(OP_RD, REG_BR, 32'h0, RESP_OKAY);
        add_step(OP_WR, REG_TRZ, 32'h0000_002A, RESP_OKAY);
        add_step(OP_RD, REG_BR, 32'h0, RESP_OKAY);
        add_step(OP_RD, REG_BRN, 32'h0, RESP_OKAY);
        add_step(OP_WR, REG_BR, 32'h0, RESP_OKAY);
        add_step(OP_RD, REG_BR, 32'h0, RESP_OKAY);
        add_step(OP_RD, REG_BRN, 32'h0, RESP_OKAY);
        for (int s = 0; s < 4; s++) begin
            s2 = s[1:0];
            for (int k = 0; k < 2; k++) begin
                wa = (k == 0) ? 4'd5 : 4'd9;
                rnd = $urandom();
                add_step(OP_WR, {STACK_BASE[11:8], s2, wa, 2'b00}, {20'h0, rnd[11:0]},
                         RESP_OKAY);
            end
        end
        // empty mask, and a different word address than the gather after it
        add_gather(4'b0000, 4'd9);
        for (int s = 0; s < 4; s++) begin
            add_gather(4'b0001 << s, 4'd5);
        end
        add_step(OP_WR, REG_BR, 32'h0, RESP_OKAY);
        add_gather(4'b0101, 4'd9);
        rnd = $urandom();
        add_step(OP_WR, REG_TRY, {20'h0, rnd[11:0]}, RESP_OKAY);
        add_gather(4'b1010, 4'd9);
        add_step(OP_WR, REG_BR, 32'h0, RESP_OKAY);
        add_gather(4'b0110, 4'd9);
        add_gather(4'b1111, 4'd9);
        // clear issued during a gather must wait for it
        add_step(OP_WR, REG_GATHER, 32'h0000_00F9, RESP_OKAY);
        add_step(OP_HOLD, REG_BR, 32'h0, RESP_OKAY);
        add_step(OP_POLL, REG_STATUS, 32'h0, RESP_OKAY);
        add_step(OP_RD, REG_BR, 32'h0, RESP_OKAY);
        add_step(OP_RD, REG_BRN, 32'h0, RESP_OKAY);
        add_step(OP_WR, REG_TRZ, 32'h0000_003C, RESP_OKAY);
        add_step(OP_WR, 12'h020, 32'h0000_0FFF, RESP_SLVERR);
        add_step(OP_RD, REG_BR, 32'h0, RESP_OKAY);
        add_step(OP_RD, 12'h030, 32'h0, RESP_SLVERR);
        add_step(OP_RD, REG_BRN, 32'h0, RESP_OKAY);
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp, output int waits);
        @(posedge v1);
        #1;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        wvalid  = 1'b1;
        waits   = 0;
        while (!(awready && wready)) begin
            @(posedge v1);
            #1;
            waits++;
        end
        @(posedge v1);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        while (!bvalid) begin
            @(posedge v1);
            #1;
        end
        resp = bresp;
        @(posedge v1);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge v1);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            @(posedge v1);
            #1;
        end
        @(posedge v1);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) begin
            @(posedge v1);
            #1;
        end
        data = rdata;
        resp = rresp;
        @(posedge v1);
        #1;
        rready = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] d;
        logic [1:0]  r;
        d = 32'h1;
        while (d[0]) begin
            axi_read(REG_STATUS, d, r);
        end
    endtask

    task automatic run_step(input int i);
        logic [31:0] d;
        logic [1:0]  r;
        int          waits;
        case (t_op[i])
            OP_WR, OP_HOLD: begin
                axi_write(t_addr[i], t_data[i], r, waits);
                check($sformatf("bresp @%h", t_addr[i]), {30'h0, r}, {30'h0, t_resp[i]});
                if (t_op[i] == OP_HOLD && waits == 0) begin
                    $display("write to %h was accepted while a gather was running", t_addr[i]);
                    errors++;
                end
            end
            OP_RD: begin
                axi_read(t_addr[i], d, r);
                check($sformatf("rdata @%h", t_addr[i]), d, t_exp[i]);
                check($sformatf("rresp @%h", t_addr[i]), {30'h0, r}, {30'h0, t_resp[i]});
            end
            OP_POLL: wait_idle();
            default: begin
                $display("table entry %0d has an unknown operation", i);
                errors++;
            end
        endcase
    endtask

    initial begin
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        void'($urandom(32'h6875));
        build_table();
        limit = 40 * t_op.size() + 200;
        repeat (2) @(posedge v1);
        #1;
        arst_n = 1'b1;
        for (int i = 0; i < t_op.size(); i++) begin
            run_step(i);
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: test/bufreg_asserts.sv
`timescale 1ns/1ps

module bufreg_asserts import bufreg_pkg::*; (
    input logic        v1,
    input logic        arst_n,
    input stack_mask_t sense_req,
    input stack_mask_t pending,
    input logic        sense_strobe,
    input logic        busy
);

    // at most one stack drives the sense bus
    req_onehot: assert property (@(posedge v1) disable iff (!arst_n)
        $onehot0(sense_req))
        else $error("sense_req %b has more than one stack selected", sense_req);

    // a strobe only while busy, and only for a stack still waiting
    strobe_in_busy: assert property (@(posedge v1) disable iff (!arst_n)
        sense_strobe |-> (busy && ((sense_req & pending) != '0)))
        else $error("sense_strobe seen while idle or for a stack that is not pending");

    // nothing left to sense, so busy must drop next cycle
    busy_falls: assert property (@(posedge v1) disable iff (!arst_n)
        (busy && pending == '0) |=> !busy)
        else $error("busy stayed high with no pending request");

endmodule

bind sense_arbiter bufreg_asserts u_asserts (
    .v1           (v1),
    .arst_n       (arst_n),
    .sense_req    (sense_req),
    .pending      (pending),
    .sense_strobe (sense_strobe),
    .busy         (busy)
);

// File: src/bufreg_top.sv
`timescale 1ns/1ps
`default_nettype none

module bufreg_top import bufreg_pkg::*; (
    input  logic        v1,
    input  logic        arst_n,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    stack_mask_t stack_we;
    waddr_t      stack_waddr;
    word_t       stack_wdata;
    word_t       tr_data;
    logic        br_clear;
    logic        tr_y;
    logic        tr_z;
    logic        gather_start;
    waddr_t      gather_addr;
    stack_mask_t gather_mask;
    stack_mask_t sense_req;
    word_t       sense_data_a;
    word_t       sense_data_b;
    word_t       sense_data_c;
    word_t       sense_data_d;
    word_t       sense_bus;
    logic        sense_strobe;
    logic        busy;
    word_t       br;
    word_t       br_n;

    axil_bufreg_port u_port (
        .v1           (v1),
        .arst_n       (arst_n),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .br           (br),
        .br_n         (br_n),
        .busy         (busy),
        .stack_we     (stack_we),
        .stack_waddr  (stack_waddr),
        .stack_wdata  (stack_wdata),
        .tr_data      (tr_data),
        .br_clear     (br_clear),
        .tr_y         (tr_y),
        .tr_z         (tr_z),
        .gather_start (gather_start),
        .gather_addr  (gather_addr),
        .gather_mask  (gather_mask)
    );

    core_stack stack_a (
        .v1 (v1), .arst_n (arst_n), .we (stack_we[0]), .waddr (stack_waddr),
        .wdata (stack_wdata), .sense_addr (gather_addr), .sense_req (sense_req[0]),
        .sense_data (sense_data_a)
    );

    core_stack stack_b (
        .v1 (v1), .arst_n (arst_n), .we (stack_we[1]), .waddr (stack_waddr),
        .wdata (stack_wdata), .sense_addr (gather_addr), .sense_req (sense_req[1]),
        .sense_data (sense_data_b)
    );

    core_stack stack_c (
        .v1 (v1), .arst_n (arst_n), .we (stack_we[2]), .waddr (stack_waddr),
        .wdata (stack_wdata), .sense_addr (gather_addr), .sense_req (sense_req[2]),
        .sense_data (sense_data_c)
    );

    core_stack stack_d (
        .v1 (v1), .arst_n (arst_n), .we (stack_we[3]), .waddr (stack_waddr),
        .wdata (stack_wdata), .sense_addr (gather_addr), .sense_req (sense_req[3]),
        .sense_data (sense_data_d)
    );

    sense_arbiter u_arbiter (
        .v1           (v1),
        .arst_n       (arst_n),
        .gather_start (gather_start),
        .gather_mask  (gather_mask),
        .sense_data_a (sense_data_a),
        .sense_data_b (sense_data_b),
        .sense_data_c (sense_data_c),
        .sense_data_d (sense_data_d),
        .sense_req    (sense_req),
        .sense_bus    (sense_bus),
        .sense_strobe (sense_strobe),
        .busy         (busy)
    );

    buffer_register u_br (
        .v1           (v1),
        .arst_n       (arst_n),
        .clear        (br_clear),
        .sense_strobe (sense_strobe),
        .sense_bus    (sense_bus),
        .tr_y         (tr_y),
        .tr_z         (tr_z),
        .tr_data      (tr_data),
        .br           (br),
        .br_n         (br_n)
    );

endmodule

`default_nettype wire

// File: src/axil_bufreg_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_bufreg_port import bufreg_pkg::*; (
    input  logic        v1,
    input  logic        arst_n,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  word_t       br,
    input  word_t       br_n,
    input  logic        busy,
    output stack_mask_t stack_we,
    output waddr_t      stack_waddr,
    output word_t       stack_wdata,
    output word_t       tr_data,
    output logic        br_clear,
    output logic        tr_y,
    output logic        tr_z,
    output logic        gather_start,
    output waddr_t      gather_addr,
    output stack_mask_t gather_mask
);

    logic   wr_hs;
    logic   rd_hs;
    logic   is_stack;
    logic   wr_hit;
    logic   rd_hit;
    word_t  wword;
    waddr_t gather_addr_q;

    // address and data are taken in the same cycle
    assign awready = !busy && !bvalid;
    assign wready  = !busy && !bvalid;
    assign wr_hs   = awvalid && awready && wvalid && wready;

    assign wword = {wstrb[1] ? wdata[11:8] : 4'h0, wstrb[0] ? wdata[7:0] : 8'h00};

    assign is_stack = (awaddr[11:8] == STACK_BASE[11:8]) && (awaddr[1:0] == 2'b00);
    assign wr_hit   = is_stack || (awaddr == REG_BR) || (awaddr == REG_TRY)
                    || (awaddr == REG_TRZ) || (awaddr == REG_GATHER);

    // commands act at the accepting edge
    assign stack_we     = (wr_hs && is_stack) ? stack_mask_t'(4'b0001 << awaddr[7:6]) : '0;
    assign stack_waddr  = awaddr[5:2];
    assign stack_wdata  = wword;
    assign tr_data      = wword;
    assign br_clear     = wr_hs && (awaddr == REG_BR);
    assign tr_y         = wr_hs && (awaddr == REG_TRY);
    assign tr_z         = wr_hs && (awaddr == REG_TRZ);
    assign gather_start = wr_hs && (awaddr == REG_GATHER);
    assign gather_mask  = wword[7:4];

    // word address stays put for the stacks during the gather
    always_ff @(posedge v1) begin
        if (gather_start) begin
            gather_addr_q <= wword[3:0];
        end
    end

    // new address is already visible at the edge that starts the gather
    assign gather_addr = gather_start ? wword[3:0] : gather_addr_q;

    always_ff @(posedge v1 or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge v1) begin
        if (wr_hs) begin
            bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign arready = !rvalid;
    assign rd_hs   = arvalid && arready;
    assign rd_hit  = (araddr == REG_BR) || (araddr == REG_BRN) || (araddr == REG_STATUS);

    always_ff @(posedge v1 or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge v1) begin
        if (rd_hs) begin
            rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
            case (araddr)
                REG_BR:     rdata <= {20'h0, br};
                REG_BRN:    rdata <= {20'h0, br_n};
                REG_STATUS: rdata <= {31'h0, busy};
                default:    rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/buffer_register.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_register import bufreg_pkg::*; (
    input  logic  v1,
    input  logic  arst_n,
    input  logic  clear,
    input  logic  sense_strobe,
    input  word_t sense_bus,
    input  logic  tr_y,
    input  logic  tr_z,
    input  word_t tr_data,
    output word_t br,
    output word_t br_n
);

    word_t set_bits;
    word_t set_sense;
    word_t set_y;
    word_t set_z;

    // every source can only set bits, never clear them
    assign set_sense = sense_strobe ? sense_bus : '0;
    assign set_y     = tr_y ? (tr_data & HALF_Y) : '0;
    assign set_z     = tr_z ? (tr_data & HALF_Z) : '0;
    assign set_bits  = set_sense | set_y | set_z;

    // both rails are held as separate flops like the original latch pair
    always_ff @(posedge v1 or negedge arst_n) begin
        if (!arst_n) begin
            br   <= '0;
            br_n <= '1;
        end else if (clear) begin
            // clear has priority over any set in the same cycle
            br   <= '0;
            br_n <= '1;
        end else begin
            br   <= br | set_bits;
            br_n <= br_n & ~set_bits;
        end
    end

endmodule

`default_nettype wire

// File: src/sense_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sense_arbiter import bufreg_pkg::*; (
    input  logic        v1,
    input  logic        arst_n,
    input  logic        gather_start,
    input  stack_mask_t gather_mask,
    input  word_t       sense_data_a,
    input  word_t       sense_data_b,
    input  word_t       sense_data_c,
    input  word_t       sense_data_d,
    output stack_mask_t sense_req,
    output word_t       sense_bus,
    output logic        sense_strobe,
    output logic        busy
);

    arb_state_t  state;
    stack_mask_t pending;
    logic [1:0]  ptr;
    logic [1:0]  cand;
    logic [1:0]  grant_idx;
    logic        found;

    // first pending stack after the last one granted
    always_comb begin
        found = 1'b0;
        grant_idx = ptr;
        cand = ptr;
        for (int i = 1; i <= NUM_STACKS; i++) begin
            cand = ptr + 2'(i);
            if (!found && pending[cand]) begin
                found = 1'b1;
                grant_idx = cand;
            end
        end
    end

    assign busy         = (state == ARB_SCAN);
    assign sense_strobe = busy && found;
    assign sense_req    = sense_strobe ? stack_mask_t'(4'b0001 << grant_idx) : '0;

    always_comb begin
        sense_bus = '0;
        if (sense_strobe) begin
            case (grant_idx)
                2'd0: sense_bus = sense_data_a;
                2'd1: sense_bus = sense_data_b;
                2'd2: sense_bus = sense_data_c;
                default: sense_bus = sense_data_d;
            endcase
        end
    end

    always_ff @(posedge v1 or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ARB_IDLE;
            pending <= '0;
            // so that stack a is first after reset
            ptr     <= 2'd3;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (gather_start) begin
                        pending <= gather_mask;
                        state   <= ARB_SCAN;
                    end
                end
                ARB_SCAN: begin
                    // one extra cycle once everything has been sensed
                    if (pending == '0) begin
                        state <= ARB_IDLE;
                    end else begin
                        pending <= pending & ~sense_req;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
            if (sense_strobe) begin
                ptr <= grant_idx;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/core_stack.sv
`timescale 1ns/1ps
`default_nettype none

module core_stack import bufreg_pkg::*; (
    input  logic   v1,
    input  logic   arst_n,
    input  logic   we,
    input  waddr_t waddr,
    input  word_t  wdata,
    input  waddr_t sense_addr,
    input  logic   sense_req,
    output word_t  sense_data
);

    // 16 words of core, readout is non-destructive here
    word_t  mem [16];
    waddr_t addr_q;

    always_ff @(posedge v1) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // address follows the host while idle and is frozen
    // for as long as this stack is being sensed
    always_ff @(posedge v1 or negedge arst_n) begin
        if (!arst_n) begin
            addr_q <= '0;
        end else if (!sense_req) begin
            addr_q <= sense_addr;
        end
    end

    // drive zero when not selected so nothing leaks onto the bus
    assign sense_data = sense_req ? mem[addr_q] : '0;

endmodule

`default_nettype wire

// File: src/bufreg_pkg.sv
package bufreg_pkg;

    // one machine word, same width in stacks, sense bus and buffer register
    typedef logic [11:0] word_t;
    typedef logic [11:0] half_sel_t;
    typedef logic [3:0]  waddr_t;
    // one bit per stack, a is bit 0
    typedef logic [3:0]  stack_mask_t;

    localparam int NUM_STACKS = 4;

    // Y half is the upper six bits, Z half the lower six
    localparam half_sel_t HALF_Y = 12'hFC0;
    localparam half_sel_t HALF_Z = 12'h03F;

    // AXI byte addresses
    localparam logic [11:0] REG_BR     = 12'h000;
    localparam logic [11:0] REG_BRN    = 12'h004;
    localparam logic [11:0] REG_TRY    = 12'h008;
    localparam logic [11:0] REG_TRZ    = 12'h00C;
    localparam logic [11:0] REG_GATHER = 12'h010;
    localparam logic [11:0] REG_STATUS = 12'h014;
    localparam logic [11:0] STACK_BASE = 12'h100;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic {
        ARB_IDLE,
        ARB_SCAN
    } arb_state_t;

endpackage
